// ==== verilog/ipv4_rx_pkg.sv ====
package ipv4_rx_pkg;

  // protocol numbers as they arrive from the ipv4 parser
  localparam logic [7:0] IP_PROTO_TCP = 8'd6;

  // default width of the ipv4 payload length and every length derived from it
  localparam int LEN_W = 16;

endpackage : ipv4_rx_pkg

// ==== verilog/tcp_rx_pkg.sv ====
package tcp_rx_pkg;

  // fixed part of the tcp header, options follow it
  localparam int TCP_HDR_LEN = 20;

  // option kind codes
  localparam logic [7:0] TCP_OPT_END       = 8'd0;
  localparam logic [7:0] TCP_OPT_NOP       = 8'd1;
  localparam logic [7:0] TCP_OPT_MSS       = 8'd2;
  localparam logic [7:0] TCP_OPT_WIN       = 8'd3;
  localparam logic [7:0] TCP_OPT_SACK_PERM = 8'd4;
  localparam logic [7:0] TCP_OPT_SACK      = 8'd5;
  localparam logic [7:0] TCP_OPT_TS        = 8'd8;

  // header fields, first wire byte in the msbs
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq;
    logic [31:0] ack;
    logic [3:0]  offset;
    logic [3:0]  rsvd;
    logic [7:0]  flags;
    logic [15:0] win;
    logic [15:0] cksum;
    logic [15:0] urg;
  } tcp_hdr_t;

  // written byte by byte, read back as fields
  typedef union packed {
    logic [TCP_HDR_LEN-1:0][7:0] bytes;
    tcp_hdr_t                    fields;
  } tcp_hdr_word_u;

  // where the frame stands
  typedef enum logic [2:0] {
    idle_s,
    hdr_s,
    opt_s,
    pld_s,
    done_s
  } tcp_rx_state_t;

  // position inside one option
  typedef enum logic [1:0] {
    fld_kind,
    fld_len,
    fld_data
  } opt_field_t;

endpackage : tcp_rx_pkg

// ==== verilog/tcp_rx_ctrl.sv ====
module tcp_rx_ctrl import ipv4_rx_pkg::*, tcp_rx_pkg::*; #(
  parameter int LEN_W = ipv4_rx_pkg::LEN_W
) (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             in_val,
  input  logic             in_sof,
  input  logic [7:0]       in_proto,
  input  logic [5:0]       offset_bytes,
  input  logic [LEN_W-1:0] pld_len,
  output tcp_rx_state_t    state,
  output logic             clr,
  output logic             hdr_last,
  output logic             opt_en,
  output logic             pld_en,
  output logic             pld_first,
  output logic             pld_last,
  output logic             hdr_val,
  output logic             done
);

  localparam int HDR_CNT_W = $clog2(TCP_HDR_LEN);

  logic [HDR_CNT_W-1:0] hdr_cnt;
  // shared by the option and the payload section
  logic [LEN_W-1:0]     seg_cnt;
  logic [5:0]           opt_bytes;
  logic                 has_opt;
  logic                 opt_last;

  // sof byte of a tcp frame is header byte 0
  assign clr = (state == idle_s) && in_val && in_sof && (in_proto == IP_PROTO_TCP);

  assign hdr_last = (state == hdr_s) && in_val &&
                    (hdr_cnt == HDR_CNT_W'(TCP_HDR_LEN - 1));

  assign has_opt   = offset_bytes > 6'(TCP_HDR_LEN);
  assign opt_bytes = offset_bytes - 6'(TCP_HDR_LEN);

  assign opt_en   = (state == opt_s) && in_val;
  assign opt_last = opt_en && (seg_cnt == LEN_W'(opt_bytes) - 1'b1);

  assign pld_en    = (state == pld_s) && in_val;
  assign pld_first = pld_en && (seg_cnt == '0);
  assign pld_last  = pld_en && (seg_cnt == pld_len - 1'b1);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= idle_s;
      hdr_cnt <= '0;
      seg_cnt <= '0;
      hdr_val <= 1'b0;
      done    <= 1'b0;
    end else begin
      hdr_val <= 1'b0;
      done    <= (state == done_s);
      case (state)
        idle_s: begin
          if (clr) begin
            hdr_cnt <= HDR_CNT_W'(1);
            state   <= hdr_s;
          end
        end
        hdr_s: begin
          if (in_val) begin
            hdr_cnt <= hdr_cnt + 1'b1;
          end
          if (hdr_last) begin
            seg_cnt <= '0;
            if (has_opt) begin
              state <= opt_s;
            end else begin
              // no options, header and length are known right now
              hdr_val <= 1'b1;
              state   <= (pld_len == '0) ? done_s : pld_s;
            end
          end
        end
        opt_s: begin
          if (opt_en) begin
            seg_cnt <= seg_cnt + 1'b1;
          end
          if (opt_last) begin
            seg_cnt <= '0;
            hdr_val <= 1'b1;
            state   <= (pld_len == '0) ? done_s : pld_s;
          end
        end
        pld_s: begin
          if (pld_en) begin
            seg_cnt <= seg_cnt + 1'b1;
          end
          if (pld_last) begin
            state <= done_s;
          end
        end
        done_s: begin
          // trailing padding is dropped in idle until the next sof
          state <= idle_s;
        end
        default: begin
          state <= idle_s;
        end
      endcase
    end
  end

endmodule : tcp_rx_ctrl

// ==== verilog/tcp_hdr_capture.sv ====
module tcp_hdr_capture import ipv4_rx_pkg::*, tcp_rx_pkg::*; #(
  parameter int LEN_W = ipv4_rx_pkg::LEN_W
) (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             clr,
  input  logic [7:0]       in_dat,
  input  logic             in_val,
  input  logic [LEN_W-1:0] in_pld_len,
  input  tcp_rx_state_t    state,
  input  logic             hdr_last,
  output tcp_hdr_t         hdr,
  output logic [5:0]       offset_bytes,
  output logic [LEN_W-1:0] pld_len
);

  tcp_hdr_word_u    shift_q;
  tcp_hdr_word_u    word_next;
  logic             shift_en;
  logic [5:0]       off_q;
  logic [LEN_W-1:0] ip_len_q;

  // byte 0 is taken in the accept cycle, the rest in the hdr state
  assign shift_en = in_val && (clr || (state == hdr_s));

  // full header once byte 19 is on the input
  always_comb begin
    word_next.bytes = {shift_q.bytes[TCP_HDR_LEN-2:0], in_dat};
  end

  always_ff @(posedge clk) begin
    if (shift_en) begin
      shift_q <= word_next;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      hdr      <= '0;
      off_q    <= '0;
      ip_len_q <= '0;
    end else if (clr) begin
      hdr      <= '0;
      off_q    <= '0;
      ip_len_q <= in_pld_len;
    end else if (hdr_last) begin
      hdr   <= word_next.fields;
      off_q <= {word_next.fields.offset, 2'b00};
    end
  end

  // ctrl needs the offset in the same cycle as the last header byte
  assign offset_bytes = hdr_last ? {word_next.fields.offset, 2'b00} : off_q;
  assign pld_len      = ip_len_q - LEN_W'(offset_bytes);

endmodule : tcp_hdr_capture

// ==== verilog/tcp_opt_parse.sv ====
module tcp_opt_parse import tcp_rx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        clr,
  input  logic [7:0]  in_dat,
  input  logic        opt_en,
  output logic        opt_mss_pres,
  output logic [15:0] opt_mss,
  output logic        opt_win_pres,
  output logic [7:0]  opt_win,
  output logic        opt_sack_perm_pres,
  output logic        opt_sack_pres,
  output logic [2:0]  opt_sack_blocks,
  output logic        opt_ts_pres,
  output logic [31:0] opt_ts
);

  opt_field_t field;
  logic [7:0] kind_q;
  // data bytes left after kind and length
  logic [7:0] rem_q;
  logic [7:0] dat_cnt;
  logic [7:0] prev_q;

  always_ff @(posedge clk) begin
    if (fsm_rst || clr) begin
      field              <= fld_kind;
      opt_mss_pres       <= 1'b0;
      opt_win_pres       <= 1'b0;
      opt_sack_perm_pres <= 1'b0;
      opt_sack_pres      <= 1'b0;
      opt_ts_pres        <= 1'b0;
    end else if (opt_en) begin
      case (field)
        fld_kind: begin
          kind_q  <= in_dat;
          dat_cnt <= '0;
          // end and nop carry no length byte
          if ((in_dat != TCP_OPT_END) && (in_dat != TCP_OPT_NOP)) begin
            field <= fld_len;
          end
          case (in_dat)
            TCP_OPT_MSS:       opt_mss_pres       <= 1'b1;
            TCP_OPT_WIN:       opt_win_pres       <= 1'b1;
            TCP_OPT_SACK_PERM: opt_sack_perm_pres <= 1'b1;
            TCP_OPT_SACK:      opt_sack_pres      <= 1'b1;
            TCP_OPT_TS:        opt_ts_pres        <= 1'b1;
            default:           ;
          endcase
        end
        fld_len: begin
          rem_q <= in_dat - 8'd2;
          field <= (in_dat > 8'd2) ? fld_data : fld_kind;
        end
        fld_data: begin
          dat_cnt <= dat_cnt + 1'b1;
          if (dat_cnt == rem_q - 8'd1) begin
            field <= fld_kind;
          end
        end
        default: begin
          field <= fld_kind;
        end
      endcase
    end
  end

  // option values, unknown kinds just pass through the data state
  always_ff @(posedge clk) begin
    if (clr) begin
      opt_mss         <= '0;
      opt_win         <= '0;
      opt_sack_blocks <= '0;
      opt_ts          <= '0;
    end else if (opt_en) begin
      prev_q <= in_dat;
      if ((field == fld_len) && (kind_q == TCP_OPT_SACK)) begin
        case (in_dat)
          8'd10:   opt_sack_blocks <= 3'd1;
          8'd18:   opt_sack_blocks <= 3'd2;
          8'd26:   opt_sack_blocks <= 3'd3;
          8'd34:   opt_sack_blocks <= 3'd4;
          default: opt_sack_blocks <= 3'd0;
        endcase
      end
      if (field == fld_data) begin
        case (kind_q)
          TCP_OPT_MSS: begin
            if (dat_cnt == 8'd1) begin
              opt_mss <= {prev_q, in_dat};
            end
          end
          TCP_OPT_WIN: begin
            if (dat_cnt == 8'd0) begin
              opt_win <= in_dat;
            end
          end
          TCP_OPT_TS: begin
            // only the sender's value, echo reply is not kept
            if (dat_cnt < 8'd4) begin
              opt_ts <= {opt_ts[23:0], in_dat};
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule : tcp_opt_parse

// ==== verilog/tcp_pld_fwd.sv ====
module tcp_pld_fwd import ipv4_rx_pkg::*; #(
  parameter int LEN_W = ipv4_rx_pkg::LEN_W
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic [7:0] in_dat,
  input  logic       pld_en,
  input  logic       pld_first,
  input  logic       pld_last,
  output logic [7:0] out_dat,
  output logic       out_val,
  output logic       out_sof,
  output logic       out_eof
);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      out_dat <= '0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
    end else begin
      out_val <= pld_en;
      out_dat <= pld_en ? in_dat : 8'h00;
      out_sof <= pld_en && pld_first;
      out_eof <= pld_en && pld_last;
    end
  end

endmodule : tcp_pld_fwd

// ==== verilog/tcp_rx_top.sv ====
module tcp_rx_top import ipv4_rx_pkg::*, tcp_rx_pkg::*; #(
  parameter int LEN_W = ipv4_rx_pkg::LEN_W
) (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic [7:0]       in_dat,
  input  logic             in_val,
  input  logic             in_sof,
  input  logic             in_eof,
  input  logic [7:0]       in_proto,
  input  logic [LEN_W-1:0] in_pld_len,
  output tcp_hdr_t         hdr,
  output logic             hdr_val,
  output logic             opt_mss_pres,
  output logic [15:0]      opt_mss,
  output logic             opt_win_pres,
  output logic [7:0]       opt_win,
  output logic             opt_sack_perm_pres,
  output logic             opt_sack_pres,
  output logic [2:0]       opt_sack_blocks,
  output logic             opt_ts_pres,
  output logic [31:0]      opt_ts,
  output logic [LEN_W-1:0] pld_len,
  output logic [7:0]       out_dat,
  output logic             out_val,
  output logic             out_sof,
  output logic             out_eof,
  output logic             done
);

  tcp_rx_state_t state;
  logic          clr;
  logic          hdr_last;
  logic          opt_en;
  logic          pld_en;
  logic          pld_first;
  logic          pld_last;
  logic [5:0]    offset_bytes;

  tcp_rx_ctrl #(
    .LEN_W (LEN_W)
  ) ctrl_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .in_val       (in_val),
    .in_sof       (in_sof),
    .in_proto     (in_proto),
    .offset_bytes (offset_bytes),
    .pld_len      (pld_len),
    .state        (state),
    .clr          (clr),
    .hdr_last     (hdr_last),
    .opt_en       (opt_en),
    .pld_en       (pld_en),
    .pld_first    (pld_first),
    .pld_last     (pld_last),
    .hdr_val      (hdr_val),
    .done         (done)
  );

  tcp_hdr_capture #(
    .LEN_W (LEN_W)
  ) hdr_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .clr          (clr),
    .in_dat       (in_dat),
    .in_val       (in_val),
    .in_pld_len   (in_pld_len),
    .state        (state),
    .hdr_last     (hdr_last),
    .hdr          (hdr),
    .offset_bytes (offset_bytes),
    .pld_len      (pld_len)
  );

  tcp_opt_parse opt_inst (
    .clk                (clk),
    .fsm_rst            (fsm_rst),
    .clr                (clr),
    .in_dat             (in_dat),
    .opt_en             (opt_en),
    .opt_mss_pres       (opt_mss_pres),
    .opt_mss            (opt_mss),
    .opt_win_pres       (opt_win_pres),
    .opt_win            (opt_win),
    .opt_sack_perm_pres (opt_sack_perm_pres),
    .opt_sack_pres      (opt_sack_pres),
    .opt_sack_blocks    (opt_sack_blocks),
    .opt_ts_pres        (opt_ts_pres),
    .opt_ts             (opt_ts)
  );

  tcp_pld_fwd #(
    .LEN_W (LEN_W)
  ) pld_inst (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .in_dat    (in_dat),
    .pld_en    (pld_en),
    .pld_first (pld_first),
    .pld_last  (pld_last),
    .out_dat   (out_dat),
    .out_val   (out_val),
    .out_sof   (out_sof),
    .out_eof   (out_eof)
  );

endmodule : tcp_rx_top

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk
);

  // free running, 10 time units per period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule : tb_clk_gen

// ==== tb/tb_tcp_rx.sv ====
module tb_tcp_rx import ipv4_rx_pkg::*, tcp_rx_pkg::*; ();

  // bytes on the wire over all five tests
  localparam int FRAME_BYTES = 32 + 48 + 53 + 24 + 58;
  localparam int CYCLE_LIMIT = FRAME_BYTES + 40 * 5;

  // one input byte with the levels and strobes that go with it
  typedef struct packed {
    logic [7:0]       proto;
    logic [LEN_W-1:0] len;
    logic             sof;
    logic             eof;
    logic [7:0]       dat;
  } beat_t;

  logic             clk;
  logic             fsm_rst;
  logic [7:0]       in_dat;
  logic             in_val;
  logic             in_sof;
  logic             in_eof;
  logic [7:0]       in_proto;
  logic [LEN_W-1:0] in_pld_len;
  tcp_hdr_t         hdr;
  logic             hdr_val;
  logic             opt_mss_pres, opt_win_pres, opt_sack_perm_pres, opt_sack_pres, opt_ts_pres;
  logic [15:0]      opt_mss;
  logic [7:0]       opt_win;
  logic [2:0]       opt_sack_blocks;
  logic [31:0]      opt_ts;
  logic [LEN_W-1:0] pld_len;
  logic [7:0]       out_dat;
  logic             out_val, out_sof, out_eof, done;

  int               err_cnt;
  int               check_cnt;
  int               err_base;
  int               test_num;
  string            test_name;
  int               cycle_cnt = 0;
  int               hdr_val_cnt;
  int               done_cnt;
  beat_t            beat_q[$];
  logic [7:0]       opt_q[$];
  logic [7:0]       pld_q[$];
  logic [7:0]       out_q[$];
  logic             out_sof_q[$];
  logic             out_eof_q[$];
  tcp_hdr_t         exp_hdr;
  logic [LEN_W-1:0] exp_pld_len;
  logic             exp_mss_pres, exp_win_pres, exp_sack_perm_pres, exp_sack_pres, exp_ts_pres;
  logic [15:0]      exp_mss;
  logic [7:0]       exp_win;
  logic [2:0]       exp_sack_blocks;
  logic [31:0]      exp_ts;

  tb_clk_gen clk_gen_inst (
    .clk (clk)
  );

  tcp_rx_top #(
    .LEN_W (LEN_W)
  ) uut (.*);

  task automatic check_hdr(input string name, input tcp_hdr_t got, input tcp_hdr_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input logic [LEN_W-1:0] got,
                           input logic [LEN_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // option values up to the 32 bit timestamp
  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name = name;
    err_base  = err_cnt;
    exp_hdr   = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
    {exp_mss_pres, exp_win_pres, exp_sack_perm_pres, exp_sack_pres, exp_ts_pres} = '0;
    {exp_mss, exp_win, exp_sack_blocks, exp_ts} = '0;
    opt_q.delete();
    pld_q.delete();
    beat_q.delete();
  endtask

  // header, then options, then payload, offset follows the option length
  task automatic add_tcp_frame();
    logic [159:0] hv;
    int           total;
    beat_t        b;
    exp_hdr.offset = 4'(5 + opt_q.size() / 4);
    hv             = exp_hdr;
    total          = TCP_HDR_LEN + opt_q.size() + pld_q.size();
    exp_pld_len    = LEN_W'(total - 4 * exp_hdr.offset);
    for (int i = 0; i < total; i++) begin
      b.proto = IP_PROTO_TCP;
      b.len   = LEN_W'(total);
      b.sof   = (i == 0);
      b.eof   = (i == total - 1);
      if (i < TCP_HDR_LEN) begin
        b.dat = hv[159 - 8 * i -: 8];
      end else if (i < TCP_HDR_LEN + opt_q.size()) begin
        b.dat = opt_q[i - TCP_HDR_LEN];
      end else begin
        b.dat = pld_q[i - TCP_HDR_LEN - opt_q.size()];
      end
      beat_q.push_back(b);
    end
  endtask

  task automatic add_raw_frame(input logic [7:0] proto, input int n);
    beat_t b;
    for (int i = 0; i < n; i++) begin
      b.proto = proto;
      b.len   = LEN_W'(n);
      b.sof   = (i == 0);
      b.eof   = (i == n - 1);
      b.dat   = 8'($urandom());
      beat_q.push_back(b);
    end
  endtask

  task automatic drive_stream();
    foreach (beat_q[i]) begin
      @(posedge clk);
      #1;
      {in_proto, in_pld_len, in_sof, in_eof, in_dat} = beat_q[i];
      in_val = 1'b1;
    end
    @(posedge clk);
    #1;
    {in_proto, in_pld_len, in_sof, in_eof, in_dat} = beat_t'(0);
    in_val = 1'b0;
  endtask

  task automatic check_fields();
    check_hdr("hdr", hdr, exp_hdr);
    check_len("pld_len", pld_len, exp_pld_len);
    check_flag("opt_mss_pres", opt_mss_pres, exp_mss_pres);
    check_flag("opt_win_pres", opt_win_pres, exp_win_pres);
    check_flag("opt_sack_perm_pres", opt_sack_perm_pres, exp_sack_perm_pres);
    check_flag("opt_sack_pres", opt_sack_pres, exp_sack_pres);
    check_flag("opt_ts_pres", opt_ts_pres, exp_ts_pres);
    check_field("opt_mss", 32'(opt_mss), 32'(exp_mss));
    check_byte("opt_win", opt_win, exp_win);
    check_field("opt_sack_blocks", 32'(opt_sack_blocks), 32'(exp_sack_blocks));
    check_field("opt_ts", opt_ts, exp_ts);
  endtask

  // outputs sampled on the falling edge, away from the driving edge
  task automatic collect_response(input int limit);
    int cyc;
    cyc         = 0;
    hdr_val_cnt = 0;
    done_cnt    = 0;
    out_q.delete();
    out_sof_q.delete();
    out_eof_q.delete();
    while ((done_cnt == 0) && (cyc < limit)) begin
      @(negedge clk);
      cyc++;
      if (hdr_val) begin
        hdr_val_cnt++;
        check_fields();
      end
      if (out_val) begin
        out_q.push_back(out_dat);
        out_sof_q.push_back(out_sof);
        out_eof_q.push_back(out_eof);
      end
      if (done) begin
        done_cnt++;
      end
    end
    if (done_cnt == 0) begin
      err_cnt++;
      $display("done did not pulse within %0d cycles", limit);
    end
  endtask

  task automatic run_and_check();
    fork
      drive_stream();
      collect_response(beat_q.size() + 40);
    join
    if (hdr_val_cnt != 1) begin
      err_cnt++;
      $display("hdr_val pulsed %0d times instead of once", hdr_val_cnt);
    end
    if (out_q.size() != pld_q.size()) begin
      err_cnt++;
      $display("out_val carried %0d bytes, payload has %0d", out_q.size(), pld_q.size());
    end else begin
      foreach (pld_q[i]) begin
        check_byte("out_dat", out_q[i], pld_q[i]);
        check_flag("out_sof", out_sof_q[i], i == 0);
        check_flag("out_eof", out_eof_q[i], i == pld_q.size() - 1);
      end
    end
    $display("test %0d %s: %0d errors", test_num, test_name, err_cnt - err_base);
  endtask

  task automatic test_plain_header();
    begin_test("plain header");
    repeat (12) pld_q.push_back(8'($urandom()));
    add_tcp_frame();
    run_and_check();
  endtask

  task automatic test_all_options();
    logic [31:0] ts_val;
    begin_test("all options");
    ts_val = $urandom();
    opt_q  = '{8'h02, 8'h04, 8'h05, 8'hb4, 8'h01, 8'h03, 8'h03, 8'h07, 8'h04, 8'h02,
               8'h08, 8'h0a, ts_val[31:24], ts_val[23:16], ts_val[15:8], ts_val[7:0]};
    // echo reply half of the timestamp
    repeat (4) opt_q.push_back(8'($urandom()));
    repeat (8) pld_q.push_back(8'($urandom()));
    {exp_mss_pres, exp_win_pres, exp_sack_perm_pres, exp_ts_pres} = 4'hf;
    exp_mss = 16'd1460;
    exp_win = 8'd7;
    exp_ts  = ts_val;
    add_tcp_frame();
    run_and_check();
  endtask

  task automatic test_sack_and_unknown();
    logic [15:0] mss;
    begin_test("sack and unknown kind");
    mss   = 16'($urandom());
    opt_q = '{8'd30, 8'd4, 8'($urandom()), 8'($urandom()),
              8'h02, 8'h04, mss[15:8], mss[7:0], 8'h05, 8'd18};
    // two sack blocks, then pad to a word
    repeat (16) opt_q.push_back(8'($urandom()));
    repeat (2) opt_q.push_back(TCP_OPT_NOP);
    repeat (5) pld_q.push_back(8'($urandom()));
    exp_mss_pres    = 1'b1;
    exp_mss         = mss;
    exp_sack_pres   = 1'b1;
    exp_sack_blocks = 3'd2;
    add_tcp_frame();
    run_and_check();
  endtask

  task automatic test_empty_payload();
    begin_test("empty payload");
    repeat (4) opt_q.push_back(TCP_OPT_NOP);
    add_tcp_frame();
    run_and_check();
  endtask

  task automatic test_foreign_then_tcp();
    begin_test("udp then tcp");
    add_raw_frame(8'd17, 28);
    opt_q = '{8'h01, 8'h03, 8'h03, 8'h04};
    repeat (6) pld_q.push_back(8'($urandom()));
    exp_win_pres = 1'b1;
    exp_win      = 8'd4;
    add_tcp_frame();
    run_and_check();
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run stopped at the cycle limit of %0d before all tests finished", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(99));
    err_cnt    = 0;
    check_cnt  = 0;
    test_num   = 0;
    fsm_rst    = 1'b1;
    in_dat     = '0;
    in_val     = 1'b0;
    in_sof     = 1'b0;
    in_eof     = 1'b0;
    in_proto   = '0;
    in_pld_len = '0;
    repeat (3) @(posedge clk);
    #1;
    fsm_rst = 1'b0;
    check_field("strobes after reset", 32'({hdr_val, out_val, out_sof, out_eof, done,
                opt_mss_pres, opt_win_pres, opt_sack_perm_pres, opt_sack_pres, opt_ts_pres}),
                32'h0);
    test_plain_header();
    test_all_options();
    test_sack_and_unknown();
    test_empty_payload();
    test_foreign_then_tcp();
    $display("summary: %0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_tcp_rx

// ==== tcp_rx_top.f ====
verilog/ipv4_rx_pkg.sv
verilog/tcp_rx_pkg.sv
verilog/tcp_rx_ctrl.sv
verilog/tcp_hdr_capture.sv
verilog/tcp_opt_parse.sv
verilog/tcp_pld_fwd.sv
verilog/tcp_rx_top.sv
tb/tb_clk_gen.sv
tb/tb_tcp_rx.sv
